/* source/ifu_pkg.sv */
`default_nettype none

package ifu_pkg;

  // bus and instruction widths
  localparam int unsigned ADDR_W = 32;
  localparam int unsigned DATA_W = 32;

  typedef logic [ADDR_W-1:0] addr_t;  // byte address
  typedef logic [DATA_W-1:0] word_t;  // instruction or bus word

  // direct-mapped L1 instruction cache geometry
  localparam int unsigned L1I_SETS  = 4;
  localparam int unsigned L1I_IDX_W = 2;
  localparam int unsigned L1I_WORDS = 2;
  localparam int unsigned L1I_OFS_W = 1;
  // tag sits above index, word offset and the 2 byte bits
  localparam int unsigned L1I_TAG_W = ADDR_W - L1I_IDX_W - L1I_OFS_W - 2;

  localparam addr_t PC_INIT = 32'h8000_0000;

  // RV32 major opcodes used for hazard classification
  localparam logic [6:0] OP_JAL    = 7'b110_1111;
  localparam logic [6:0] OP_JALR   = 7'b110_0111;
  localparam logic [6:0] OP_BRANCH = 7'b110_0011;
  localparam logic [6:0] OP_SYSTEM = 7'b111_0011;
  localparam logic [6:0] OP_LOAD   = 7'b000_0011;

  localparam word_t INST_FENCE_I = 32'h0000_100F;  // fence.i with all fields zero

  // two single-word reads with one idle cycle in between
  typedef enum logic [2:0] {
    RF_IDLE  = 3'd0,  // lookup, request word 0 on a miss
    RF_WAIT0 = 3'd1,
    RF_GAP   = 3'd2,
    RF_WAIT1 = 3'd3,
    RF_DONE  = 3'd4   // line valid, lookup again
  } refill_state_t;

  typedef enum logic {
    FS_IDLE       = 1'b0,  // stalled until the next stage resolves the pc
    FS_WAIT_READY = 1'b1   // presenting instructions
  } fetch_state_t;

endpackage

`default_nettype wire

/* source/ifu_pc_ctrl.sv */
`default_nettype none
`timescale 1ns/10ps

module ifu_pc_ctrl (
  input  logic           clk,
  input  logic           rst,

  // redirect from the resolving stage
  input  logic           prev_valid_i,
  input  logic           pc_valid_i,
  input  logic           pc_skip_i,
  input  ifu_pkg::addr_t npc_i,

  input  logic           next_ready_i,

  // cache side
  input  ifu_pkg::word_t inst_i,
  input  logic           hit_i,
  input  logic           just_loaded_i,

  output ifu_pkg::addr_t pc_o,
  output logic           valid_o,
  output logic           ready_o,
  output logic           flush_o
);
  import ifu_pkg::*;

  fetch_state_t fetch_state;
  addr_t        pc;
  logic         hazard;

  logic [6:0]   opcode;
  logic         is_ctrl;
  logic         is_load;
  logic         accept;
  logic         redirect;

  assign opcode = inst_i[6:0];

  // jumps, branches and system instructions need the resolved pc
  assign is_ctrl = (opcode == OP_JAL) ||
                   (opcode == OP_JALR) ||
                   (opcode == OP_BRANCH) ||
                   (opcode == OP_SYSTEM);
  assign is_load = (opcode == OP_LOAD);

  // a refill completion shows its word even before the hit path catches up
  assign valid_o = just_loaded_i | (hit_i & ~hazard);
  assign ready_o = ~valid_o;
  assign pc_o    = pc;

  assign accept = valid_o & next_ready_i;

  // pc_valid only resolves control flow, pc_skip resolves both kinds
  assign redirect = (fetch_state == FS_IDLE) && prev_valid_i &&
                    ((is_ctrl && pc_valid_i) ||
                     ((is_ctrl || is_load) && pc_skip_i));

  assign flush_o = accept && (inst_i == INST_FENCE_I);

  always_ff @(posedge clk) begin
    if (rst) begin
      fetch_state <= FS_WAIT_READY;
      pc          <= PC_INIT;
      hazard      <= 1'b0;
    end else begin
      case (fetch_state)
        FS_IDLE: begin
          if (redirect) begin
            pc          <= npc_i;
            hazard      <= 1'b0;
            fetch_state <= FS_WAIT_READY;
          end
        end
        FS_WAIT_READY: begin
          if (accept) begin
            if (is_ctrl || is_load) begin
              hazard      <= 1'b1;  // pc held on the stalling instruction
              fetch_state <= FS_IDLE;
            end else begin
              pc <= pc + addr_t'(4);
            end
          end
        end
        default: begin
          fetch_state <= FS_WAIT_READY;
        end
      endcase
    end
  end

endmodule

`default_nettype wire

/* source/ifu_l1i_cache.sv */
`default_nettype none
`timescale 1ns/10ps

module ifu_l1i_cache (
  input  logic           clk,
  input  logic           rst,

  input  ifu_pkg::addr_t pc_i,
  input  logic           flush_i,

  output ifu_pkg::word_t inst_o,
  output logic           hit_o,
  output logic           just_loaded_o,

  // word-read bus
  output ifu_pkg::addr_t ifu_araddr_o,
  output logic           ifu_arvalid_o,
  input  ifu_pkg::word_t ifu_rdata_i,
  input  logic           ifu_rvalid_i
);
  import ifu_pkg::*;

  word_t                data_arr [L1I_SETS][L1I_WORDS];
  logic [L1I_TAG_W-1:0] tag_arr  [L1I_SETS];
  logic [L1I_SETS-1:0]  line_valid;

  refill_state_t        rf_state;

  logic [L1I_TAG_W-1:0] pc_tag;
  logic [L1I_IDX_W-1:0] pc_idx;
  logic [L1I_OFS_W-1:0] pc_ofs;

  logic                 lookup_ok;
  logic                 word0_phase;
  logic [L1I_OFS_W-1:0] req_ofs;    // offset of the word on the bus
  logic                 fill_we;

  assign pc_tag = pc_i[ADDR_W-1 -: L1I_TAG_W];
  assign pc_idx = pc_i[L1I_OFS_W+2 +: L1I_IDX_W];
  assign pc_ofs = pc_i[2 +: L1I_OFS_W];

  // tags are rewritten mid refill, so only trust them between refills
  assign lookup_ok = (rf_state == RF_IDLE) || (rf_state == RF_DONE);
  assign hit_o     = lookup_ok && line_valid[pc_idx] && (tag_arr[pc_idx] == pc_tag);

  assign word0_phase = (rf_state == RF_IDLE) || (rf_state == RF_WAIT0);
  assign req_ofs     = word0_phase ? '0 : L1I_OFS_W'(1);

  assign ifu_araddr_o = {pc_i[ADDR_W-1:L1I_OFS_W+2], req_ofs, 2'b00};

  // level held from request to response, dropped in the gap and done cycles
  always_comb begin
    case (rf_state)
      RF_IDLE:  ifu_arvalid_o = ~hit_o;
      RF_WAIT0: ifu_arvalid_o = 1'b1;
      RF_WAIT1: ifu_arvalid_o = 1'b1;
      default:  ifu_arvalid_o = 1'b0;
    endcase
  end

  assign just_loaded_o = (rf_state == RF_WAIT1) && ifu_rvalid_i;

  // word 1 is not in the array yet when it arrives
  assign inst_o = (just_loaded_o && pc_i[2]) ? ifu_rdata_i : data_arr[pc_idx][pc_ofs];

  assign fill_we = ifu_rvalid_i && ((rf_state == RF_WAIT0) || (rf_state == RF_WAIT1));

  always_ff @(posedge clk) begin
    if (fill_we) begin
      data_arr[pc_idx][req_ofs] <= ifu_rdata_i;
      tag_arr[pc_idx]           <= pc_tag;
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      rf_state   <= RF_IDLE;
      line_valid <= '0;
    end else begin
      case (rf_state)
        RF_IDLE: begin
          if (ifu_arvalid_o) begin
            rf_state <= RF_WAIT0;
          end
        end
        RF_WAIT0: begin
          if (ifu_rvalid_i) begin
            rf_state <= RF_GAP;
          end
        end
        RF_GAP: begin
          rf_state <= RF_WAIT1;
        end
        RF_WAIT1: begin
          if (ifu_rvalid_i) begin
            rf_state           <= RF_DONE;
            line_valid[pc_idx] <= 1'b1;
          end
        end
        RF_DONE: begin
          rf_state <= RF_IDLE;
        end
        default: begin
          rf_state <= RF_IDLE;
        end
      endcase

      // fence.i drops every line, also one finishing this cycle
      if (flush_i) begin
        line_valid <= '0;
      end
    end
  end

endmodule

`default_nettype wire

/* source/ifu_top.sv */
`default_nettype none
`timescale 1ns/10ps

module ifu_top (
  input  logic           clk,
  input  logic           rst,

  // memory read bus
  output ifu_pkg::addr_t ifu_araddr_o,
  output logic           ifu_arvalid_o,
  input  ifu_pkg::word_t ifu_rdata_i,
  input  logic           ifu_rvalid_i,

  // redirect from the resolving stage
  input  ifu_pkg::addr_t npc_i,
  input  logic           pc_valid_i,
  input  logic           pc_skip_i,
  input  logic           prev_valid_i,

  // to the next pipeline stage
  output ifu_pkg::word_t inst_o,
  output ifu_pkg::addr_t pc_o,
  output logic           valid_o,
  input  logic           next_ready_i,
  output logic           ready_o
);
  import ifu_pkg::*;

  addr_t pc;
  word_t inst;
  logic  hit;
  logic  just_loaded;
  logic  flush;

  assign pc_o   = pc;
  assign inst_o = inst;

  ifu_pc_ctrl pc_ctrl0 (
    .clk           (clk),
    .rst           (rst),
    .prev_valid_i  (prev_valid_i),
    .pc_valid_i    (pc_valid_i),
    .pc_skip_i     (pc_skip_i),
    .npc_i         (npc_i),
    .next_ready_i  (next_ready_i),
    .inst_i        (inst),
    .hit_i         (hit),
    .just_loaded_i (just_loaded),
    .pc_o          (pc),
    .valid_o       (valid_o),
    .ready_o       (ready_o),
    .flush_o       (flush)
  );

  ifu_l1i_cache l1i0 (
    .clk           (clk),
    .rst           (rst),
    .pc_i          (pc),
    .flush_i       (flush),
    .inst_o        (inst),
    .hit_o         (hit),
    .just_loaded_o (just_loaded),
    .ifu_araddr_o  (ifu_araddr_o),
    .ifu_arvalid_o (ifu_arvalid_o),
    .ifu_rdata_i   (ifu_rdata_i),
    .ifu_rvalid_i  (ifu_rvalid_i)
  );

endmodule

`default_nettype wire

/* dv/ifu_tb_mem.sv */
`default_nettype none
`timescale 1ns/10ps

module ifu_tb_mem #(
  parameter int SEED = 1
) (
  input  logic           clk,
  input  logic           rst,
  input  ifu_pkg::addr_t araddr_i,
  input  logic           arvalid_i,
  output ifu_pkg::word_t rdata_o,
  output logic           rvalid_o
);
  import ifu_pkg::*;

  localparam int         IMG_WORDS = 64;
  localparam int         IMG_LINES = 32;
  localparam logic [6:0] OP_IMM    = 7'b001_0011;  // ordinary alu op

  word_t       image    [IMG_WORDS];  // addresses past the image wrap onto it
  int          rd_count [IMG_LINES];
  int          order_errs;

  integer      seed;
  int          kind;
  int          delay;
  logic        busy;
  logic        rst_s;
  logic        arv_s;
  logic        rv_s;
  addr_t       ara_s;
  addr_t       req_addr;
  logic        want_word1;
  logic [28:0] open_line;

  initial begin
    seed = SEED;
    for (int i = 0; i < IMG_WORDS; i++) begin
      kind     = $unsigned($random(seed)) % 16;
      image[i] = $random(seed);
      if (kind < 10) begin
        image[i][6:0] = OP_IMM;
      end else if (kind < 13) begin
        image[i][6:0] = OP_BRANCH;
      end else if (kind < 15) begin
        image[i][6:0] = OP_LOAD;
      end else begin
        image[i] = INST_FENCE_I;
      end
    end
    for (int l = 0; l < IMG_LINES; l++) begin
      rd_count[l] = 0;
    end
    order_errs = 0;
    busy       = 1'b0;
    want_word1 = 1'b0;
    open_line  = '0;
    delay      = 0;
    req_addr   = '0;
    rvalid_o   = 1'b0;
    rdata_o    = '0;
    forever begin
      @(negedge clk);
      rst_s = rst;  // reset as the dut saw it at the coming edge
      arv_s = arvalid_i;
      ara_s = araddr_i;
      rv_s  = rvalid_o;  // a request seen with its own response is already served
      @(posedge clk);
      #1;
      rvalid_o = 1'b0;
      rdata_o  = '0;
      if (rst_s) begin
        busy = 1'b0;
      end else begin
        if (!busy && arv_s && !rv_s) begin
          busy     = 1'b1;
          delay    = $unsigned($random(seed)) % 4;  // 1 to 4 cycles latency
          req_addr = ara_s;
        end else if (busy) begin
          delay = delay - 1;
        end
        if (busy && delay == 0) begin
          rvalid_o = 1'b1;
          rdata_o  = image[req_addr[7:2]];
          rd_count[req_addr[7:3]] = rd_count[req_addr[7:3]] + 1;
          // word 0 opens a line, word 1 of the same line closes it
          if (req_addr[2] == 1'b0) begin
            if (want_word1) order_errs++;
            want_word1 = 1'b1;
            open_line  = req_addr[31:3];
          end else begin
            if (!want_word1 || open_line != req_addr[31:3]) order_errs++;
            want_word1 = 1'b0;
          end
          busy = 1'b0;
        end
      end
    end
  end

endmodule

`default_nettype wire

/* dv/ifu_tb.sv */
`default_nettype none
`timescale 1ns/10ps

module ifu_tb;
  import ifu_pkg::*;

  localparam int MEM_SEED   = 68018;
  localparam int NUM_ACCEPT = 2000;
  localparam int IDLE_LIMIT = 200;

  logic  clk;
  logic  rst;
  addr_t ifu_araddr;
  logic  ifu_arvalid;
  word_t ifu_rdata;
  logic  ifu_rvalid;
  addr_t npc;
  logic  pc_valid;
  logic  pc_skip;
  logic  prev_valid;
  logic  next_ready;
  word_t inst;
  addr_t pc;
  logic  valid;
  logic  ready;

  integer seed;
  int     err_count;
  int     check_total;
  int     accepted;
  int     flushes;
  int     idle_cycles;
  logic   timed_out;

  // reference model: pc stream and a direct-mapped tag/valid copy
  addr_t       model_pc;
  logic        stalled;
  logic        stall_on_load;
  int          redirect_delay;
  logic [26:0] model_tag   [4];  // pc[31:5], set is pc[4:3]
  logic        model_valid [4];
  int          exp_count   [32];

  logic  prev_hold;
  addr_t prev_pc;
  word_t prev_inst;
  logic  prev_arvalid;
  addr_t prev_araddr;
  logic  prev_rvalid;

  logic  nxt_ready;
  logic  nxt_prev_valid;
  logic  nxt_pc_valid;
  logic  nxt_pc_skip;
  addr_t nxt_npc;

  ifu_top dut0 (
    .clk           (clk),
    .rst           (rst),
    .ifu_araddr_o  (ifu_araddr),
    .ifu_arvalid_o (ifu_arvalid),
    .ifu_rdata_i   (ifu_rdata),
    .ifu_rvalid_i  (ifu_rvalid),
    .npc_i         (npc),
    .pc_valid_i    (pc_valid),
    .pc_skip_i     (pc_skip),
    .prev_valid_i  (prev_valid),
    .inst_o        (inst),
    .pc_o          (pc),
    .valid_o       (valid),
    .next_ready_i  (next_ready),
    .ready_o       (ready)
  );

  ifu_tb_mem #(.SEED(MEM_SEED)) mem0 (
    .clk       (clk),
    .rst       (rst),
    .araddr_i  (ifu_araddr),
    .arvalid_i (ifu_arvalid),
    .rdata_o   (ifu_rdata),
    .rvalid_o  (ifu_rvalid)
  );

  initial begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  task automatic check_addr(input string name, input addr_t got, input addr_t exp);
    check_total++;
    if (got !== exp) begin
      err_count++;
      $display("MISMATCH t=%0t %s got %h expected %h", $time, name, got, exp);
    end
  endtask

  task automatic check_word(input string name, input word_t got, input word_t exp);
    check_total++;
    if (got !== exp) begin
      err_count++;
      $display("MISMATCH t=%0t %s got %h expected %h", $time, name, got, exp);
    end
  endtask

  task automatic check_count(input string name, input int got, input int exp);
    check_total++;
    if (got != exp) begin
      err_count++;
      $display("MISMATCH t=%0t %s got %0d expected %0d", $time, name, got, exp);
    end
  endtask

  task automatic check_flag(input string name, input logic got, input logic exp);
    check_total++;
    if (got !== exp) begin
      err_count++;
      $display("MISMATCH t=%0t %s got %b expected %b", $time, name, got, exp);
    end
  endtask

  function automatic logic is_flow(input word_t w);
    return (w[6:0] == OP_JAL) || (w[6:0] == OP_JALR) ||
           (w[6:0] == OP_BRANCH) || (w[6:0] == OP_SYSTEM);
  endfunction

  function automatic logic is_load(input word_t w);
    return w[6:0] == OP_LOAD;
  endfunction

  task automatic record_accept();
    word_t       exp_inst;
    logic [1:0]  set;
    logic [26:0] tag;
    logic [4:0]  line;
    exp_inst = mem0.image[model_pc[7:2]];
    set      = model_pc[4:3];
    tag      = model_pc[31:5];
    line     = model_pc[7:3];
    check_addr("pc_o", pc, model_pc);
    check_word("inst_o", inst, exp_inst);
    if (!(model_valid[set] && model_tag[set] == tag)) begin
      exp_count[line] += 2;  // miss refills both words
      model_valid[set] = 1'b1;
      model_tag[set]   = tag;
    end
    check_count("reads of line", mem0.rd_count[line], exp_count[line]);
    check_count("out of order reads", mem0.order_errs, 0);
    if (exp_inst == INST_FENCE_I) begin
      for (int s = 0; s < 4; s++) begin
        model_valid[s] = 1'b0;
      end
      flushes++;
      model_pc = model_pc + addr_t'(4);
    end else if (is_flow(exp_inst) || is_load(exp_inst)) begin
      stalled        = 1'b1;
      stall_on_load  = is_load(exp_inst);
      redirect_delay = $unsigned($random(seed)) % 4;
    end else begin
      model_pc = model_pc + addr_t'(4);
    end
  endtask

  task automatic sample_cycle();
    if (ifu_arvalid) begin
      if (prev_arvalid && !prev_rvalid) begin
        check_addr("ifu_araddr_o held", ifu_araddr, prev_araddr);
      end
      check_addr("ifu_araddr_o line", ifu_araddr & ~addr_t'(4), {pc[31:3], 3'b000});
    end
    check_flag("ready_o", ready, ~valid);
    if (prev_hold) begin
      check_flag("valid_o held", valid, 1'b1);
      check_addr("pc_o held", pc, prev_pc);
      check_word("inst_o held", inst, prev_inst);
    end
    if (stalled) check_flag("valid_o in hazard", valid, 1'b0);
    if (valid && next_ready) begin
      record_accept();
      accepted++;
      idle_cycles = 0;
    end else begin
      idle_cycles++;
    end
    if (prev_valid) begin  // redirect is taken at the coming edge
      model_pc = npc;
      stalled  = 1'b0;
    end
    prev_hold    = valid && !next_ready;
    prev_pc      = pc;
    prev_inst    = inst;
    prev_arvalid = ifu_arvalid;
    prev_araddr  = ifu_araddr;
    prev_rvalid  = ifu_rvalid;
  endtask

  task automatic choose_inputs();
    nxt_ready      = ($unsigned($random(seed)) % 4) != 0;
    nxt_prev_valid = 1'b0;
    nxt_pc_valid   = 1'b0;
    nxt_pc_skip    = 1'b0;
    nxt_npc        = '0;
    if (stalled) begin
      if (redirect_delay > 0) begin
        redirect_delay--;
      end else begin
        nxt_prev_valid = 1'b1;
        if (!stall_on_load && ($unsigned($random(seed)) % 2) == 1) begin
          nxt_pc_valid = 1'b1;  // taken, somewhere in the image
          nxt_npc      = PC_INIT + addr_t'(($unsigned($random(seed)) % 64) * 4);
        end else begin
          nxt_pc_skip = 1'b1;
          nxt_npc     = model_pc + addr_t'(4);
        end
      end
    end
  endtask

  initial begin
    seed           = 68018;
    err_count      = 0;
    check_total    = 0;
    accepted       = 0;
    flushes        = 0;
    idle_cycles    = 0;
    timed_out      = 1'b0;
    model_pc       = PC_INIT;
    stalled        = 1'b0;
    stall_on_load  = 1'b0;
    redirect_delay = 0;
    for (int s = 0; s < 4; s++) begin
      model_valid[s] = 1'b0;
      model_tag[s]   = '0;
    end
    for (int l = 0; l < 32; l++) begin
      exp_count[l] = 0;
    end
    prev_hold    = 1'b0;
    prev_pc      = '0;
    prev_inst    = '0;
    prev_arvalid = 1'b0;
    prev_araddr  = '0;
    prev_rvalid  = 1'b0;
    rst          = 1'b1;
    next_ready   = 1'b0;
    prev_valid   = 1'b0;
    pc_valid     = 1'b0;
    pc_skip      = 1'b0;
    npc          = '0;
    repeat (5) @(posedge clk);
    #1;
    rst = 1'b0;

    // outputs sampled mid cycle, inputs changed just after the edge
    while (accepted < NUM_ACCEPT && !timed_out) begin
      @(negedge clk);
      sample_cycle();
      choose_inputs();
      if (idle_cycles > IDLE_LIMIT) begin
        $display("TIMEOUT: no instruction accepted for %0d cycles at t=%0t",
                 IDLE_LIMIT, $time);
        timed_out = 1'b1;
      end
      @(posedge clk);
      #1;
      next_ready = nxt_ready;
      prev_valid = nxt_prev_valid;
      pc_valid   = nxt_pc_valid;
      pc_skip    = nxt_pc_skip;
      npc        = nxt_npc;
    end

    $display("checks %0d errors %0d accepted %0d fence.i %0d timeout %0d",
             check_total, err_count, accepted, flushes, timed_out);
    if (err_count == 0 && !timed_out) begin
      $display("=== PASS ===");
    end else begin
      $display("=== FAIL ===");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* all.f */
source/ifu_pkg.sv
source/ifu_pc_ctrl.sv
source/ifu_l1i_cache.sv
source/ifu_top.sv
dv/ifu_tb_mem.sv
dv/ifu_tb.sv

/* run.sh */
#!/bin/sh

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --timescale 1ns/10ps --top-module ifu_tb \
  -f all.f -o ifu_sim
build_status=$?
if [ $build_status -ne 0 ]; then
  echo "verilator build failed with status $build_status"
  exit 1
fi

sim_out=$(./obj_dir/ifu_sim)
sim_status=$?
printf '%s\n' "$sim_out"
if [ $sim_status -ne 0 ]; then
  echo "simulation exited with status $sim_status"
  exit 1
fi

if printf '%s\n' "$sim_out" | grep -qx -e '=== PASS ==='; then
  exit 0
fi
echo "pass message not found in simulation output"
exit 1
